/* hdl/tinker_pkg.sv */
package tinker_pkg;

    // basic widths
    localparam int WORD_W    = 64;
    localparam int INST_W    = 32;
    localparam int DADDR_W   = 32;
    localparam int OPCODE_W  = 5;
    localparam int REG_IDX_W = 5;
    localparam int LIT_W     = 12;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [WORD_W-1:0]    addr_t;
    typedef logic [DADDR_W-1:0]   daddr_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [LIT_W-1:0]     literal_t;

    // fetch starts here after reset
    localparam addr_t RESET_PC   = 64'h2000;
    localparam addr_t INST_BYTES = 64'd4;
    localparam int    NUM_REGS   = 32;

    // instruction field positions
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 27;
    localparam int RD_HI     = 26;
    localparam int RD_LO     = 22;
    localparam int RS_HI     = 21;
    localparam int RS_LO     = 17;
    localparam int RT_HI     = 16;
    localparam int RT_LO     = 12;
    localparam int LIT_HI    = 11;
    localparam int LIT_LO    = 0;

    // supported opcodes
    localparam opcode_t OP_AND    = 5'b00000;
    localparam opcode_t OP_OR     = 5'b00001;
    localparam opcode_t OP_XOR    = 5'b00010;
    localparam opcode_t OP_NOT    = 5'b00011;
    localparam opcode_t OP_SHFTR  = 5'b00100;
    localparam opcode_t OP_SHFTRI = 5'b00101;
    localparam opcode_t OP_SHFTL  = 5'b00110;
    localparam opcode_t OP_SHFTLI = 5'b00111;
    localparam opcode_t OP_JUMP   = 5'b01000;
    localparam opcode_t OP_BRNZ   = 5'b01011;
    localparam opcode_t OP_HALT   = 5'b01111;
    localparam opcode_t OP_MOV    = 5'b10001;
    localparam opcode_t OP_MOVL   = 5'b10010;
    localparam opcode_t OP_STORE  = 5'b10011;
    localparam opcode_t OP_ADD    = 5'b11000;
    localparam opcode_t OP_ADDI   = 5'b11001;
    localparam opcode_t OP_SUB    = 5'b11010;
    localparam opcode_t OP_SUBI   = 5'b11011;

    // operand bypass slots
    localparam int NUM_BYPASS = 3;
    localparam int BYP_RS     = 0;
    localparam int BYP_RT     = 1;
    localparam int BYP_RD     = 2;

endpackage

/* hdl/tinker_decoder.sv */
`timescale 1ns/1ps

module tinker_decoder (
    input  tinker_pkg::inst_t    inst,
    input  logic                 valid,
    output tinker_pkg::opcode_t  opcode,
    output tinker_pkg::reg_idx_t rd,
    output tinker_pkg::reg_idx_t rs,
    output tinker_pkg::reg_idx_t rt,
    output tinker_pkg::literal_t literal,
    output logic                 uses_literal,
    output logic                 writes_reg,
    output logic                 is_halt
);
    import tinker_pkg::*;

    // fixed field slices, same layout for every format
    assign opcode  = inst[OPCODE_HI:OPCODE_LO];
    assign rd      = inst[RD_HI:RD_LO];
    assign rs      = inst[RS_HI:RS_LO];
    assign rt      = inst[RT_HI:RT_LO];
    assign literal = inst[LIT_HI:LIT_LO];

    // operand source and write-back class
    always_comb begin
        uses_literal = 1'b0;
        writes_reg   = 1'b0;
        case (opcode)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOVL: begin
                uses_literal = 1'b1;
                writes_reg   = 1'b1;
            end
            // store takes L as offset, writes no register
            OP_STORE: uses_literal = 1'b1;
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT,
            OP_SHFTR, OP_SHFTL, OP_MOV: begin
                writes_reg = 1'b1;
            end
            // jump, brnz, halt and unknown codes
            default: ;
        endcase
    end

    // only a real instruction may stop fetch
    assign is_halt = valid && (opcode == OP_HALT);

endmodule

/* hdl/tinker_fetch.sv */
`timescale 1ns/1ps

module tinker_fetch (
    input  logic              clk,
    input  logic              reset,
    output tinker_pkg::addr_t imem_addr,
    input  tinker_pkg::inst_t imem_data,
    input  logic              redirect,
    input  tinker_pkg::addr_t redirect_pc,
    input  logic              halt_seen,
    output tinker_pkg::inst_t fetch_inst,
    output tinker_pkg::addr_t fetch_pc,
    output logic              fetch_valid
);
    import tinker_pkg::*;

    addr_t pc;
    logic  frozen;
    logic  advance;

    // instruction memory answers combinationally
    assign imem_addr = pc;

    // normal step only when no redirect and no halt pending
    assign advance = !redirect && !frozen && !halt_seen;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= RESET_PC;
            fetch_valid <= 1'b0;
            frozen      <= 1'b0;
        end else if (redirect) begin
            // branch wins over a halt sitting in its shadow
            pc          <= redirect_pc;
            fetch_valid <= 1'b0;
        end else if (frozen || halt_seen) begin
            // halt decoded, stay put until reset
            frozen      <= 1'b1;
            fetch_valid <= 1'b0;
        end else begin
            pc          <= pc + INST_BYTES;
            fetch_valid <= 1'b1;
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (advance) begin
            fetch_inst <= imem_data;
            fetch_pc   <= pc;
        end
    end

endmodule

/* hdl/tinker_regfile.sv */
`timescale 1ns/1ps

module tinker_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::reg_idx_t rs,
    input  tinker_pkg::reg_idx_t rt,
    input  tinker_pkg::reg_idx_t rd,
    input  logic                 uses_literal,
    input  tinker_pkg::literal_t literal,
    output tinker_pkg::word_t    rs_val,
    output tinker_pkg::word_t    rt_val,
    output tinker_pkg::word_t    rd_val,
    input  logic                 we,
    input  tinker_pkg::reg_idx_t wr_idx,
    input  tinker_pkg::word_t    wr_val
);
    import tinker_pkg::*;

    word_t regs [NUM_REGS];

    // same-cycle write shows up on the read side
    function automatic word_t read_port(reg_idx_t idx);
        word_t val;
        val = regs[idx];
        if (we && (wr_idx == idx)) begin
            val = wr_val;
        end
        return val;
    endfunction

    always_comb begin
        rs_val = read_port(rs);
        rd_val = read_port(rd);
        // literal forms see sign-extended L in the rt slot
        if (uses_literal) begin
            rt_val = {{(WORD_W-LIT_W){literal[LIT_W-1]}}, literal};
        end else begin
            rt_val = read_port(rt);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_val;
        end
    end

endmodule

/* hdl/tinker_operand_bypass.sv */
`timescale 1ns/1ps

module tinker_operand_bypass (
    input  tinker_pkg::reg_idx_t idx,
    input  tinker_pkg::word_t    staged_val,
    input  logic                 is_literal,
    input  logic                 mem_we,
    input  tinker_pkg::reg_idx_t mem_idx,
    input  tinker_pkg::word_t    mem_val,
    input  logic                 wb_we,
    input  tinker_pkg::reg_idx_t wb_idx,
    input  tinker_pkg::word_t    wb_val,
    output tinker_pkg::word_t    operand
);
    import tinker_pkg::*;

    logic hit_mem;
    logic hit_wb;

    // producer one stage ahead
    assign hit_mem = mem_we && (mem_idx == idx);
    // producer two stages ahead
    assign hit_wb  = wb_we && (wb_idx == idx);

    always_comb begin
        if (is_literal) begin
            // sign-extended L, no register behind it
            operand = staged_val;
        end else if (hit_mem) begin
            // newest value wins
            operand = mem_val;
        end else if (hit_wb) begin
            operand = wb_val;
        end else begin
            // older writes already landed in the register file
            operand = staged_val;
        end
    end

endmodule

/* hdl/tinker_alu.sv */
`timescale 1ns/1ps

module tinker_alu (
    input  tinker_pkg::opcode_t  opcode,
    input  tinker_pkg::addr_t    pc,
    input  tinker_pkg::word_t    rs_op,
    input  tinker_pkg::word_t    rt_op,
    input  tinker_pkg::word_t    rd_op,
    input  tinker_pkg::literal_t literal,
    output tinker_pkg::word_t    result,
    output logic                 store,
    output tinker_pkg::daddr_t   store_addr,
    output tinker_pkg::word_t    store_data,
    output logic                 redirect,
    output tinker_pkg::addr_t    redirect_pc
);
    import tinker_pkg::*;

    // amounts of 64 and up clear the word
    function automatic word_t shift(word_t val, word_t amt, logic left);
        word_t res;
        if (amt > word_t'(WORD_W - 1)) begin
            res = '0;
        end else if (left) begin
            res = val << amt[5:0];
        end else begin
            res = val >> amt[5:0];
        end
        return res;
    endfunction

    always_comb begin
        result      = '0;
        store       = 1'b0;
        // rt_op carries sign-extended L for store
        store_addr  = daddr_t'(rd_op + rt_op);
        store_data  = rs_op;
        redirect    = 1'b0;
        redirect_pc = pc + INST_BYTES;
        case (opcode)
            OP_ADD:    result = rs_op + rt_op;
            OP_SUB:    result = rs_op - rt_op;
            // immediate forms work on rd in place
            OP_ADDI:   result = rd_op + rt_op;
            OP_SUBI:   result = rd_op - rt_op;
            OP_AND:    result = rs_op & rt_op;
            OP_OR:     result = rs_op | rt_op;
            OP_XOR:    result = rs_op ^ rt_op;
            OP_NOT:    result = ~rs_op;
            OP_SHFTR:  result = shift(rs_op, rt_op, 1'b0);
            OP_SHFTL:  result = shift(rs_op, rt_op, 1'b1);
            OP_SHFTRI: result = shift(rd_op, rt_op, 1'b0);
            OP_SHFTLI: result = shift(rd_op, rt_op, 1'b1);
            OP_MOV:    result = rs_op;
            // low 12 bits replaced, upper part of rd kept
            OP_MOVL:   result = {rd_op[WORD_W-1:LIT_W], literal};
            OP_STORE:  store = 1'b1;
            OP_JUMP: begin
                redirect    = 1'b1;
                redirect_pc = rd_op;
            end
            OP_BRNZ: begin
                if (rs_op != '0) begin
                    redirect    = 1'b1;
                    redirect_pc = rd_op;
                end
            end
            default: ;
        endcase
    end

endmodule

/* hdl/tinker_core.sv */
`timescale 1ns/1ps

module tinker_core (
    input  logic               clk,
    input  logic               reset,
    output tinker_pkg::addr_t  imem_addr,
    input  tinker_pkg::inst_t  imem_data,
    output logic               dmem_we,
    output tinker_pkg::daddr_t dmem_addr,
    output tinker_pkg::word_t  dmem_wdata,
    output logic               hlt
);
    import tinker_pkg::*;

    // IF/ID
    inst_t    fetch_inst;
    addr_t    fetch_pc;
    logic     fetch_valid;

    // decode outputs
    opcode_t  dec_opcode;
    reg_idx_t dec_rd;
    reg_idx_t dec_rs;
    reg_idx_t dec_rt;
    literal_t dec_literal;
    logic     dec_uses_literal;
    logic     dec_writes_reg;
    logic     dec_is_halt;
    word_t    rs_val;
    word_t    rt_val;
    word_t    rd_val;

    // ID/EX
    logic     id_ex_valid;
    logic     id_ex_we;
    logic     id_ex_halt;
    opcode_t  id_ex_opcode;
    addr_t    id_ex_pc;
    reg_idx_t id_ex_rd;
    reg_idx_t id_ex_rs;
    reg_idx_t id_ex_rt;
    literal_t id_ex_literal;
    logic     id_ex_uses_literal;
    word_t    id_ex_rs_val;
    word_t    id_ex_rt_val;
    word_t    id_ex_rd_val;

    // execute
    reg_idx_t byp_idx    [NUM_BYPASS];
    word_t    byp_staged [NUM_BYPASS];
    logic     byp_lit    [NUM_BYPASS];
    word_t    byp_out    [NUM_BYPASS];
    word_t    alu_result;
    logic     alu_store;
    daddr_t   alu_store_addr;
    word_t    alu_store_data;
    logic     alu_redirect;
    addr_t    alu_redirect_pc;
    logic     redirect;

    // EX/MEM
    logic     ex_mem_valid;
    logic     ex_mem_we;
    logic     ex_mem_store;
    logic     ex_mem_halt;
    reg_idx_t ex_mem_rd;
    word_t    ex_mem_result;
    daddr_t   ex_mem_addr;
    word_t    ex_mem_data;
    logic     ex_mem_wr;

    // MEM/WB
    logic     mem_wb_valid;
    logic     mem_wb_we;
    reg_idx_t mem_wb_rd;
    word_t    mem_wb_result;
    logic     mem_wb_wr;

    tinker_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .redirect    (redirect),
        .redirect_pc (alu_redirect_pc),
        .halt_seen   (dec_is_halt),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid)
    );

    tinker_decoder u_decoder (
        .inst         (fetch_inst),
        .valid        (fetch_valid),
        .opcode       (dec_opcode),
        .rd           (dec_rd),
        .rs           (dec_rs),
        .rt           (dec_rt),
        .literal      (dec_literal),
        .uses_literal (dec_uses_literal),
        .writes_reg   (dec_writes_reg),
        .is_halt      (dec_is_halt)
    );

    tinker_regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .rs           (dec_rs),
        .rt           (dec_rt),
        .rd           (dec_rd),
        .uses_literal (dec_uses_literal),
        .literal      (dec_literal),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .rd_val       (rd_val),
        .we           (mem_wb_wr),
        .wr_idx       (mem_wb_rd),
        .wr_val       (mem_wb_result)
    );

    // ID/EX control, cleared behind a taken redirect
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex_valid <= 1'b0;
            id_ex_we    <= 1'b0;
            id_ex_halt  <= 1'b0;
        end else begin
            id_ex_valid <= fetch_valid && !redirect;
            id_ex_we    <= dec_writes_reg;
            id_ex_halt  <= dec_is_halt;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_opcode       <= dec_opcode;
        id_ex_pc           <= fetch_pc;
        id_ex_rd           <= dec_rd;
        id_ex_rs           <= dec_rs;
        id_ex_rt           <= dec_rt;
        id_ex_literal      <= dec_literal;
        id_ex_uses_literal <= dec_uses_literal;
        id_ex_rs_val       <= rs_val;
        id_ex_rt_val       <= rt_val;
        id_ex_rd_val       <= rd_val;
    end

    // bypass slots, only rt can hold a literal
    assign byp_idx[BYP_RS]    = id_ex_rs;
    assign byp_idx[BYP_RT]    = id_ex_rt;
    assign byp_idx[BYP_RD]    = id_ex_rd;
    assign byp_staged[BYP_RS] = id_ex_rs_val;
    assign byp_staged[BYP_RT] = id_ex_rt_val;
    assign byp_staged[BYP_RD] = id_ex_rd_val;
    assign byp_lit[BYP_RS]    = 1'b0;
    assign byp_lit[BYP_RT]    = id_ex_uses_literal;
    assign byp_lit[BYP_RD]    = 1'b0;

    // write flags only count for live entries
    assign ex_mem_wr = ex_mem_valid && ex_mem_we;
    assign mem_wb_wr = mem_wb_valid && mem_wb_we;

    for (genvar i = 0; i < NUM_BYPASS; i++) begin : g_bypass
        tinker_operand_bypass u_bypass (
            .idx        (byp_idx[i]),
            .staged_val (byp_staged[i]),
            .is_literal (byp_lit[i]),
            .mem_we     (ex_mem_wr),
            .mem_idx    (ex_mem_rd),
            .mem_val    (ex_mem_result),
            .wb_we      (mem_wb_wr),
            .wb_idx     (mem_wb_rd),
            .wb_val     (mem_wb_result),
            .operand    (byp_out[i])
        );
    end

    tinker_alu u_alu (
        .opcode      (id_ex_opcode),
        .pc          (id_ex_pc),
        .rs_op       (byp_out[BYP_RS]),
        .rt_op       (byp_out[BYP_RT]),
        .rd_op       (byp_out[BYP_RD]),
        .literal     (id_ex_literal),
        .result      (alu_result),
        .store       (alu_store),
        .store_addr  (alu_store_addr),
        .store_data  (alu_store_data),
        .redirect    (alu_redirect),
        .redirect_pc (alu_redirect_pc)
    );

    // a bubble never redirects
    assign redirect = id_ex_valid && alu_redirect;

    // EX/MEM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem_valid <= 1'b0;
            ex_mem_we    <= 1'b0;
            ex_mem_store <= 1'b0;
            ex_mem_halt  <= 1'b0;
        end else begin
            ex_mem_valid <= id_ex_valid;
            ex_mem_we    <= id_ex_we;
            ex_mem_store <= alu_store;
            ex_mem_halt  <= id_ex_halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_rd     <= id_ex_rd;
        ex_mem_result <= alu_result;
        ex_mem_addr   <= alu_store_addr;
        ex_mem_data   <= alu_store_data;
    end

    // store strobe for one cycle per live store
    assign dmem_we    = ex_mem_valid && ex_mem_store;
    assign dmem_addr  = ex_mem_addr;
    assign dmem_wdata = ex_mem_data;

    // MEM/WB, plus sticky halt as the halt enters it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb_valid <= 1'b0;
            mem_wb_we    <= 1'b0;
            hlt          <= 1'b0;
        end else begin
            mem_wb_valid <= ex_mem_valid;
            mem_wb_we    <= ex_mem_we;
            if (ex_mem_valid && ex_mem_halt) begin
                hlt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_rd     <= ex_mem_rd;
        mem_wb_result <= ex_mem_result;
    end

endmodule

/* verif/tinker_assertions.sv */
`timescale 1ns/1ps

module tinker_assertions (
    input logic clk,
    input logic reset,
    input logic dmem_we,
    input logic hlt
);

    // halt is sticky until reset
    hlt_sticky: assert property (@(posedge clk) disable iff (reset) $past(hlt) |-> hlt)
        else $error("hlt fell without reset");

    // nothing reaches memory once halted
    no_store_halted: assert property (@(posedge clk) disable iff (reset) hlt |-> !dmem_we)
        else $error("dmem_we high while hlt is high");

    // strobe always resolved out of reset
    we_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(dmem_we))
        else $error("dmem_we is unknown");

endmodule

/* verif/tinker_tb.sv */
`timescale 1ns/1ps

module tinker_tb;
    import tinker_pkg::*;

    localparam int PROG_WORDS      = 256;
    localparam int NUM_TESTS       = 5;
    localparam int MAX_TEST_CYCLES = 200;
    localparam int CYCLE_LIMIT     = NUM_TESTS * MAX_TEST_CYCLES;
    localparam logic [15:0] LFSR_SEED = 16'd94;

    logic   clk;
    logic   reset;
    addr_t  imem_addr;
    inst_t  imem_data;
    logic   dmem_we;
    daddr_t dmem_addr;
    word_t  dmem_wdata;
    logic   hlt;

    // program image with one instruction per slot from RESET_PC
    inst_t prog [PROG_WORDS];
    int    prog_len;

    // observed and predicted store streams
    daddr_t got_addr [$];
    word_t  got_data [$];
    logic   got_hlt  [$];
    daddr_t exp_addr [$];
    word_t  exp_data [$];

    int          value_errors;
    int          other_errors;
    int          cycles;
    logic [15:0] lfsr_state;

    tinker_core i_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .hlt        (hlt)
    );

    bind tinker_core tinker_assertions i_assertions (
        .clk     (clk),
        .reset   (reset),
        .dmem_we (dmem_we),
        .hlt     (hlt)
    );

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

    // anything outside the program image reads as halt
    always_comb begin
        addr_t offset;
        offset = imem_addr - RESET_PC;
        imem_data = {OP_HALT, 27'd0};
        if ((imem_addr >= RESET_PC) && (offset < addr_t'(PROG_WORDS * 4))
            && (offset[1:0] == 2'b00)) begin
            imem_data = prog[offset[9:2]];
        end
    end

    // store strobe is steady at the falling edge
    always @(negedge clk) begin
        if (dmem_we === 1'b1) begin
            got_addr.push_back(dmem_addr);
            got_data.push_back(dmem_wdata);
            got_hlt.push_back(hlt);
        end
    end

    // run limit over all tests
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: hlt not reached within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // fibonacci lfsr with taps 16 14 13 11 and one step per bit
    function automatic word_t random_bits(int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[WORD_W-2:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic inst_t encode(opcode_t op, reg_idx_t rd, reg_idx_t rs,
                                     reg_idx_t rt, literal_t lit);
        return {op, rd, rs, rt, lit};
    endfunction

    function automatic word_t sext(literal_t lit);
        return {{(WORD_W-LIT_W){lit[LIT_W-1]}}, lit};
    endfunction

    function automatic addr_t slot_addr(int idx);
        return RESET_PC + addr_t'(idx * 4);
    endfunction

    // register form rules where shifts of 64 and up give zero
    function automatic word_t reg_rule(opcode_t op, word_t a, word_t b);
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_NOT:   return ~a;
            OP_SHFTR: return (b >= 64) ? '0 : (a >> b);
            OP_SHFTL: return (b >= 64) ? '0 : (a << b);
            default:  return a;
        endcase
    endfunction

    task automatic clear_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {OP_HALT, 27'd0};
        end
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(inst_t inst);
        prog[prog_len] = inst;
        prog_len++;
    endtask

    // 4 + 5 x 12 bits built from the top chunk down
    task automatic emit_load(reg_idx_t r, word_t value);
        emit(encode(OP_MOVL, r, 5'd0, 5'd0, literal_t'(value[63:60])));
        for (int i = 4; i >= 0; i--) begin
            emit(encode(OP_SHFTLI, r, 5'd0, 5'd0, 12'd12));
            emit(encode(OP_MOVL, r, 5'd0, 5'd0, value[12*i +: 12]));
        end
    endtask

    // store through r0 so the address is just the sign-extended L
    task automatic emit_store(reg_idx_t r, literal_t offset);
        emit(encode(OP_STORE, 5'd0, r, 5'd0, offset));
    endtask

    task automatic expect_store(literal_t offset, word_t data);
        exp_addr.push_back(daddr_t'(sext(offset)));
        exp_data.push_back(data);
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_addr(string name, daddr_t expected, daddr_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    // reset for 3 cycles then wait for hlt
    task automatic run_program();
        @(negedge clk);
        reset = 1'b1;
        repeat (3) @(negedge clk);
        got_addr.delete();
        got_data.delete();
        got_hlt.delete();
        reset = 1'b0;
        while (hlt !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_stores(string name);
        int n;
        n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        if (got_addr.size() != exp_addr.size()) begin
            other_errors++;
            $display("%s: expected %0d stores but the core made %0d", name,
                     exp_addr.size(), got_addr.size());
        end
        for (int i = 0; i < n; i++) begin
            check_addr(name, exp_addr[i], got_addr[i]);
            check_word(name, exp_data[i], got_data[i]);
            if (got_hlt[i] !== 1'b0) begin
                other_errors++;
                $display("%s: store %0d happened while hlt was already high", name, i);
            end
        end
    endtask

    // dependent ops back to back with the results stored at the end
    task automatic test_reg_ops();
        word_t a;
        word_t b;
        word_t e3;
        word_t e4;
        word_t e5;
        word_t e6;
        word_t e7;
        a = 64'h0F0F_1234_8765_A5A5;
        b = 64'h00FF_00FF_7777_0001;
        clear_program();
        emit_load(5'd1, a);
        emit_load(5'd2, b);
        emit(encode(OP_ADD, 5'd3, 5'd1, 5'd2, 12'd0));
        emit(encode(OP_SUB, 5'd4, 5'd3, 5'd1, 12'd0));
        emit(encode(OP_AND, 5'd5, 5'd4, 5'd1, 12'd0));
        // r3 comes back through the write-through read
        emit(encode(OP_OR,  5'd6, 5'd5, 5'd3, 12'd0));
        emit(encode(OP_XOR, 5'd7, 5'd6, 5'd3, 12'd0));
        emit(encode(OP_NOT, 5'd8, 5'd7, 5'd0, 12'd0));
        for (int r = 3; r <= 8; r++) begin
            emit_store(reg_idx_t'(r), literal_t'(8 * r));
        end
        e3 = a + b;
        e4 = e3 - a;
        e5 = e4 & a;
        e6 = e5 | e3;
        e7 = e6 ^ e3;
        expect_store(12'd24, e3);
        expect_store(12'd32, e4);
        expect_store(12'd40, e5);
        expect_store(12'd48, e6);
        expect_store(12'd56, e7);
        expect_store(12'd64, ~e7);
        run_program();
        compare_stores("reg_ops");
    endtask

    task automatic test_literal_ops();
        word_t c;
        word_t d;
        c = 64'h0123_4567_89AB_CDEF;
        d = 64'hFEDC_BA98_7654_3210;
        clear_program();
        emit_load(5'd1, c);
        // negative L
        emit(encode(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'hFFB));
        emit_store(5'd1, 12'h000);
        emit(encode(OP_SUBI, 5'd1, 5'd0, 5'd0, 12'h7FF));
        emit_store(5'd1, 12'h008);
        emit_load(5'd2, c);
        emit(encode(OP_SHFTRI, 5'd2, 5'd0, 5'd0, 12'd4));
        emit_store(5'd2, 12'h010);
        emit_load(5'd3, c);
        emit(encode(OP_SHFTLI, 5'd3, 5'd0, 5'd0, 12'd64));
        emit_store(5'd3, 12'h018);
        // all-ones L is a huge amount once extended
        emit_load(5'd4, d);
        emit(encode(OP_SHFTRI, 5'd4, 5'd0, 5'd0, 12'hFFF));
        emit_store(5'd4, 12'h020);
        emit_load(5'd5, d);
        emit(encode(OP_MOVL, 5'd5, 5'd0, 5'd0, 12'hABC));
        emit_store(5'd5, 12'h028);
        expect_store(12'h000, c + sext(12'hFFB));
        expect_store(12'h008, c + sext(12'hFFB) - sext(12'h7FF));
        expect_store(12'h010, c >> 4);
        expect_store(12'h018, '0);
        expect_store(12'h020, '0);
        expect_store(12'h028, {d[63:12], 12'hABC});
        run_program();
        compare_stores("literal_ops");
    endtask

    // shadow stores behind a taken brnz and a jump must vanish
    task automatic test_control();
        clear_program();
        emit_load(5'd1, slot_addr(32));
        emit_load(5'd2, slot_addr(48));
        emit(encode(OP_MOVL, 5'd9, 5'd0, 5'd0, 12'd1));
        emit(encode(OP_MOVL, 5'd10, 5'd0, 5'd0, 12'h111));
        emit(encode(OP_BRNZ, 5'd1, 5'd9, 5'd0, 12'd0));
        emit_store(5'd10, 12'h100);
        emit_store(5'd10, 12'h108);
        prog_len = 32;
        emit_store(5'd9, 12'h020);
        // r0 is zero so brnz falls through
        emit(encode(OP_BRNZ, 5'd2, 5'd0, 5'd0, 12'd0));
        emit_store(5'd10, 12'h028);
        emit(encode(OP_JUMP, 5'd2, 5'd0, 5'd0, 12'd0));
        emit_store(5'd9, 12'h110);
        emit_store(5'd9, 12'h118);
        prog_len = 48;
        emit_store(5'd10, 12'h030);
        expect_store(12'h020, 64'd1);
        expect_store(12'h028, 64'h111);
        expect_store(12'h030, 64'h111);
        run_program();
        compare_stores("control");
    endtask

    task automatic test_random_ops();
        opcode_t ops [9];
        opcode_t op;
        word_t   x;
        word_t   y;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHFTR, OP_SHFTL, OP_MOV};
        clear_program();
        for (int k = 0; k < 4; k++) begin
            op = ops[int'(random_bits(4)) % 9];
            x  = random_bits(64);
            // small amounts so shifts land on both sides of 64
            y  = ((op == OP_SHFTR) || (op == OP_SHFTL)) ? random_bits(7) : random_bits(64);
            emit_load(5'd1, x);
            emit_load(5'd2, y);
            emit(encode(op, 5'd3, 5'd1, 5'd2, 12'd0));
            emit_store(5'd3, literal_t'(8 * k));
            expect_store(literal_t'(8 * k), reg_rule(op, x, y));
        end
        run_program();
        compare_stores("random_ops");
    endtask

    // stores past the halt in memory must never be made
    task automatic test_halt();
        clear_program();
        emit(encode(OP_MOVL, 5'd1, 5'd0, 5'd0, 12'h055));
        emit_store(5'd1, 12'h040);
        emit(encode(OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0));
        emit_store(5'd1, 12'h048);
        emit_store(5'd1, 12'h050);
        expect_store(12'h040, 64'h55);
        run_program();
        repeat (10) begin
            @(negedge clk);
            if (hlt !== 1'b1) begin
                other_errors++;
                $display("halt: hlt dropped without a reset");
            end
        end
        compare_stores("halt");
    endtask

    initial begin
        reset        = 1'b1;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        lfsr_state   = LFSR_SEED;
        clear_program();
        test_reg_ops();
        test_literal_ops();
        test_control();
        test_random_ops();
        test_halt();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
hdl/tinker_pkg.sv
hdl/tinker_decoder.sv
hdl/tinker_fetch.sv
hdl/tinker_regfile.sv
hdl/tinker_operand_bypass.sv
hdl/tinker_alu.sv
hdl/tinker_core.sv
verif/tinker_assertions.sv
verif/tinker_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tinker_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)
